/* mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// datapath word width
`define MIPS_DATA_W     32

// architectural register file size
`define MIPS_REG_NUM    32

// bits needed to index a register
`define MIPS_REG_ADDR_W 5

`endif

/* mips_core_stim.txt */
// valid  instruction  wb_en  wb_addr  wb_data   (all hex, one line per clock cycle)
// wb_addr and wb_data are don't care when wb_en is 0
1 3c018000 1 01 80000000  // lui   r1, 0x8000
1 34028001 1 02 00008001  // ori   r2, r0, 0x8001
1 2403fff0 1 03 fffffff0  // addiu r3, r0, 0xfff0
1 3c047fff 1 04 7fff0000  // lui   r4, 0x7fff
1 3484ffff 1 04 7fffffff  // ori   r4, r4, 0xffff
1 30658f0f 1 05 00008f00  // andi  r5, r3, 0x8f0f
1 3866ffff 1 06 ffff000f  // xori  r6, r3, 0xffff
1 00663824 1 07 ffff0000  // and   r7, r3, r6
1 00454025 1 08 00008f01  // or    r8, r2, r5
1 00244826 1 09 ffffffff  // xor   r9, r1, r4
1 00465027 1 0a 00007ff0  // nor   r10, r2, r6
1 0022582a 1 0b 00000001  // slt   r11, r1, r2
1 0022602b 1 0c 00000000  // sltu  r12, r1, r2
1 0043682a 1 0d 00000000  // slt   r13, r2, r3
1 0043702b 1 0e 00000001  // sltu  r14, r2, r3
1 00027900 1 0f 00080010  // sll   r15, r2, 4
1 000187c2 1 10 00000001  // srl   r16, r1, 31
1 00038883 1 11 fffffffc  // sra   r17, r3, 2
1 24120024 1 12 00000024  // addiu r18, r0, 0x24
1 02429804 1 13 00080010  // sllv  r19, r2, r18
1 0241a006 1 14 08000000  // srlv  r20, r1, r18
1 0241a807 1 15 f8000000  // srav  r21, r1, r18
1 24160005 1 16 00000005  // addiu r22, r0, 5
1 02d6b021 1 16 0000000a  // addu  r22, r22, r22
1 02d6b021 1 16 00000014  // addu  r22, r22, r22
1 02d2b823 1 17 fffffff0  // subu  r23, r22, r18
1 24180777 1 18 00000777  // addiu r24, r0, 0x777
1 0084c020 0 00 00000000  // add   r24, r4, r4 overflows
1 0024c022 0 00 00000000  // sub   r24, r1, r4 overflows
1 20980001 0 00 00000000  // addi  r24, r4, 1 overflows
1 0084c821 1 19 fffffffe  // addu  r25, r4, r4
1 371a0000 1 1a 00000777  // ori   r26, r24, 0
1 0024d823 1 1b 00000001  // subu  r27, r1, r4
1 34000055 1 00 00000055  // ori   r0, r0, 0x55
1 0002e025 1 1c 00008001  // or    r28, r0, r2
0 3c1d1234 0 00 00000000  // idle, lui r29 on the bus
1 8c1d0000 0 00 00000000  // lw    r29 is not decoded
1 0022e80a 0 00 00000000  // movz  r29 is not decoded
1 03a0f021 1 1e 00000000  // addu  r30, r29, r0
1 0009f821 1 1f ffffffff  // addu  r31, r0, r9

/* mips_core_top.sv */
`timescale 1ns/1ps

module mips_core_top
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;
    alu_op_e   id_alu_op;
    word_t     id_opa;
    word_t     id_opb;
    logic      id_wreg;
    reg_addr_t id_waddr;
    word_t     ex_result;
    logic      ex_ovf;
    logic      ex_wreg;
    reg_addr_t ex_waddr;

    mips_id_stage i_mips_id_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs_data_i    (rs_data),
        .rt_data_i    (rt_data),
        .ex_wreg_i    (ex_wreg),
        .ex_waddr_i   (ex_waddr),
        .ex_wdata_i   (ex_result),
        .wb_wreg_i    (wb_en_o),    // older forwarding source
        .wb_waddr_i   (wb_addr_o),
        .wb_wdata_i   (wb_data_o),
        .rs_addr_o    (rs_addr),
        .rt_addr_o    (rt_addr),
        .alu_op_o     (id_alu_op),
        .opa_o        (id_opa),
        .opb_o        (id_opb),
        .wreg_o       (id_wreg),
        .waddr_o      (id_waddr)
    );

    mips_ex_stage i_mips_ex_stage (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .alu_op_i (id_alu_op),
        .opa_i    (id_opa),
        .opb_i    (id_opb),
        .wreg_i   (id_wreg),
        .waddr_i  (id_waddr),
        .result_o (ex_result),
        .ovf_o    (ex_ovf),
        .wreg_o   (ex_wreg),
        .waddr_o  (ex_waddr)
    );

    mips_wb_stage i_mips_wb_stage (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .result_i  (ex_result),
        .ovf_i     (ex_ovf),
        .wreg_i    (ex_wreg),
        .waddr_i   (ex_waddr),
        .wb_en_o   (wb_en_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

    mips_regfile i_mips_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .we_i      (wb_en_o),
        .waddr_i   (wb_addr_o),
        .wdata_i   (wb_data_o),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

endmodule

/* mips_ex_stage.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_ex_stage
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  alu_op_e   alu_op_i,
    input  word_t     opa_i,
    input  word_t     opb_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    output word_t     result_o,
    output logic      ovf_o,
    output logic      wreg_o,
    output reg_addr_t waddr_o
);

    localparam int MSB  = `MIPS_DATA_W - 1;
    localparam int SH_W = $clog2(`MIPS_DATA_W);

    word_t                 sum;
    word_t                 diff;
    logic [`MIPS_DATA_W:0] sum_wide;   // sign-extended by one bit
    logic [`MIPS_DATA_W:0] diff_wide;

    assign sum  = opa_i + opb_i;
    assign diff = opa_i - opb_i;

    assign sum_wide  = {opa_i[MSB], opa_i} + {opb_i[MSB], opb_i};
    assign diff_wide = {opa_i[MSB], opa_i} - {opb_i[MSB], opb_i};

    always_comb
    begin
        case (alu_op_i)
            ALU_AND:           result_o = opa_i & opb_i;
            ALU_OR:            result_o = opa_i | opb_i;
            ALU_XOR:           result_o = opa_i ^ opb_i;
            ALU_NOR:           result_o = ~(opa_i | opb_i);
            ALU_ADD, ALU_ADDU: result_o = sum;
            ALU_SUB, ALU_SUBU: result_o = diff;
            ALU_SLT:           result_o = word_t'($signed(opa_i) < $signed(opb_i));
            ALU_SLTU:          result_o = word_t'(opa_i < opb_i);
            ALU_SLL:           result_o = opb_i << opa_i[SH_W-1:0];
            ALU_SRL:           result_o = opb_i >> opa_i[SH_W-1:0];
            ALU_SRA:           result_o = word_t'($signed(opb_i) >>> opa_i[SH_W-1:0]);
            default:           result_o = '0;
        endcase
    end

    // signed overflow, trapping forms only
    always_comb
    begin
        case (alu_op_i)
            ALU_ADD: ovf_o = (opa_i[MSB] == opb_i[MSB]) && (sum[MSB] != opa_i[MSB]);
            ALU_SUB: ovf_o = (opa_i[MSB] != opb_i[MSB]) && (diff[MSB] != opa_i[MSB]);
            default: ovf_o = 1'b0;
        endcase
    end

    assign wreg_o  = wreg_i & ~ovf_o;  // trapped result is never forwarded
    assign waddr_o = waddr_i;

    // overflow when the two top bits of the wide result differ
    a_ovf_trap_only: assert property (@(posedge clk) disable iff (!rst_n_i)
        ovf_o == ((alu_op_i == ALU_ADD && sum_wide[MSB+1] != sum_wide[MSB]) ||
                  (alu_op_i == ALU_SUB && diff_wide[MSB+1] != diff_wide[MSB])));

endmodule

/* mips_id_stage.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_id_stage
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  logic      wb_wreg_i,
    input  reg_addr_t wb_waddr_i,
    input  word_t     wb_wdata_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    output alu_op_e   alu_op_o,
    output word_t     opa_o,
    output word_t     opb_o,
    output logic      wreg_o,
    output reg_addr_t waddr_o
);

    logic      valid_q;
    inst_t     inst_q;
    opcode_e   op;
    funct_e    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    sa;
    imm16_t    imm;
    word_t     imm_zext;
    word_t     imm_sext;
    word_t     imm_upper;
    alu_op_e   dec_op;
    logic      dec_wreg;
    reg_addr_t dec_waddr;
    logic      rd_a;
    logic      rd_b;
    word_t     ext_a;
    word_t     ext_b;
    word_t     opa_d;
    word_t     opb_d;

    function automatic logic fwd_hit(input logic rd_en, input logic wen,
                                     input reg_addr_t waddr, input reg_addr_t raddr);
        return rd_en && wen && (waddr != '0) && (waddr == raddr);
    endfunction

    // instruction register at the sampling edge
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            valid_q <= 1'b0;
            inst_q  <= '0;
        end
        else
        begin
            valid_q <= inst_valid_i;
            inst_q  <= inst_i;
        end
    end

    assign op        = opcode_e'(inst_q[31:26]);
    assign funct     = funct_e'(inst_q[5:0]);
    assign rs        = inst_q[25:21];
    assign rt        = inst_q[20:16];
    assign rd        = inst_q[15:11];
    assign sa        = inst_q[10:6];
    assign imm       = inst_q[15:0];
    assign imm_zext  = {{(`MIPS_DATA_W-16){1'b0}}, imm};
    assign imm_sext  = {{(`MIPS_DATA_W-16){imm[15]}}, imm};
    assign imm_upper = {imm, {(`MIPS_DATA_W-16){1'b0}}};
    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    always_comb
    begin
        dec_op    = ALU_NOP;
        dec_wreg  = 1'b0;
        dec_waddr = rd;
        rd_a      = 1'b0;
        rd_b      = 1'b0;
        ext_a     = '0;
        ext_b     = '0;
        case (op)
            OP_SPECIAL:
            begin
                if (sa == '0)  // register forms need a zero shamt
                begin
                    rd_a     = 1'b1;
                    rd_b     = 1'b1;
                    dec_wreg = 1'b1;
                    case (funct)
                        F_AND:   dec_op = ALU_AND;
                        F_OR:    dec_op = ALU_OR;
                        F_XOR:   dec_op = ALU_XOR;
                        F_NOR:   dec_op = ALU_NOR;
                        F_ADD:   dec_op = ALU_ADD;
                        F_ADDU:  dec_op = ALU_ADDU;
                        F_SUB:   dec_op = ALU_SUB;
                        F_SUBU:  dec_op = ALU_SUBU;
                        F_SLT:   dec_op = ALU_SLT;
                        F_SLTU:  dec_op = ALU_SLTU;
                        F_SLLV:  dec_op = ALU_SLL;
                        F_SRLV:  dec_op = ALU_SRL;
                        F_SRAV:  dec_op = ALU_SRA;
                        default:
                        begin
                            rd_a     = 1'b0;
                            rd_b     = 1'b0;
                            dec_wreg = 1'b0;
                        end
                    endcase
                end
                if (rs == '0)  // immediate shifts, amount taken as operand a
                begin
                    case (funct)
                        F_SLL:   dec_op = ALU_SLL;
                        F_SRL:   dec_op = ALU_SRL;
                        F_SRA:   dec_op = ALU_SRA;
                        default: ;
                    endcase
                    if (funct inside {F_SLL, F_SRL, F_SRA})
                    begin
                        rd_a     = 1'b0;
                        rd_b     = 1'b1;
                        dec_wreg = 1'b1;
                        ext_a    = word_t'(sa);
                    end
                end
            end
            OP_ORI, OP_ANDI, OP_XORI, OP_ADDI, OP_ADDIU:
            begin
                rd_a      = 1'b1;
                dec_wreg  = 1'b1;
                dec_waddr = rt;
                ext_b     = imm_zext;
                case (op)
                    OP_ORI:  dec_op = ALU_OR;
                    OP_ANDI: dec_op = ALU_AND;
                    OP_XORI: dec_op = ALU_XOR;
                    OP_ADDI:
                    begin
                        dec_op = ALU_ADD;
                        ext_b  = imm_sext;
                    end
                    default:
                    begin
                        dec_op = ALU_ADDU;
                        ext_b  = imm_sext;
                    end
                endcase
            end
            OP_LUI:
            begin
                dec_op    = ALU_OR;  // 0 | imm<<16
                dec_wreg  = 1'b1;
                dec_waddr = rt;
                ext_b     = imm_upper;
            end
            default: ;
        endcase
        if (!valid_q)
        begin
            dec_op   = ALU_NOP;
            dec_wreg = 1'b0;
        end
    end

    // younger stage wins over older, then the register file
    assign opa_d = !rd_a ? ext_a :
                   fwd_hit(rd_a, ex_wreg_i, ex_waddr_i, rs) ? ex_wdata_i :
                   fwd_hit(rd_a, wb_wreg_i, wb_waddr_i, rs) ? wb_wdata_i : rs_data_i;
    assign opb_d = !rd_b ? ext_b :
                   fwd_hit(rd_b, ex_wreg_i, ex_waddr_i, rt) ? ex_wdata_i :
                   fwd_hit(rd_b, wb_wreg_i, wb_waddr_i, rt) ? wb_wdata_i : rt_data_i;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            alu_op_o <= ALU_NOP;
            wreg_o   <= 1'b0;
        end
        else
        begin
            alu_op_o <= dec_op;
            wreg_o   <= dec_wreg;
        end
    end

    always_ff @(posedge clk)
    begin
        opa_o   <= opa_d;
        opb_o   <= opb_d;
        waddr_o <= dec_waddr;
    end

    // r0 reads zero even while a younger stage writes r0
    a_rs_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_q && rd_a && rs == '0) |-> opa_d == '0);
    a_rt_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (valid_q && rd_b && rt == '0) |-> opb_d == '0);

endmodule

/* mips_isa_pkg.sv */
package mips_isa_pkg;

    // primary opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef logic [31:0] inst_t;
    typedef logic [15:0] imm16_t;
    typedef logic [4:0]  shamt_t;

endpackage

/* mips_pipe_pkg.sv */
`include "mips_config.svh"

package mips_pipe_pkg;

    typedef logic [`MIPS_DATA_W-1:0]     word_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,
        ALU_AND  = 4'd1,
        ALU_OR   = 4'd2,
        ALU_XOR  = 4'd3,
        ALU_NOR  = 4'd4,
        ALU_ADD  = 4'd5,  // traps on overflow
        ALU_ADDU = 4'd6,
        ALU_SUB  = 4'd7,  // traps on overflow
        ALU_SUBU = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10,
        ALU_SLL  = 4'd11,
        ALU_SRL  = 4'd12,
        ALU_SRA  = 4'd13
    } alu_op_e;

endpackage

/* mips_regfile.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module mips_regfile
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  reg_addr_t rs_addr_i,
    input  reg_addr_t rt_addr_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o
);

    word_t regs [`MIPS_REG_NUM];

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `MIPS_REG_NUM; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we_i && (waddr_i != '0))  // r0 is never written
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rs_data_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rt_data_o = (rt_addr_i == '0) ? '0 : regs[rt_addr_i];

endmodule

/* mips_wb_stage.sv */
`timescale 1ns/1ps

module mips_wb_stage
    import mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  word_t     result_i,
    input  logic      ovf_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    output logic      wb_en_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
            wb_en_o <= 1'b0;
        else
            wb_en_o <= wreg_i & ~ovf_i;  // overflow cancels the write
    end

    always_ff @(posedge clk)
    begin
        wb_addr_o <= waddr_i;
        wb_data_o <= result_i;
    end

    a_wb_en_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(wb_en_o));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict taken from the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module tb_mips_core -o Vtb_mips_core

# the simulator exits nonzero on a fatal check, so the log carries the verdict
./obj_dir/Vtb_mips_core 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "no pass line found in $LOG"
    exit 1
fi
echo "simulation passed"

/* tb_mips_core.sv */
`timescale 1ns/1ps
`include "mips_config.svh"

module tb_mips_core
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 3;
    localparam int LATENCY    = 2;  // sampling edge to write-back edge
    localparam int WD_MARGIN  = 20;

    logic      clk;
    logic      rst_n_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;

    // stimulus table, one entry per cycle
    logic      stim_valid[$];
    inst_t     stim_inst[$];
    logic      stim_en[$];
    reg_addr_t stim_addr[$];
    word_t     stim_data[$];
    int        n_lines     = 0;
    logic      stim_loaded = 1'b0;

    // write-backs still in flight
    int        exp_due[$];
    logic      exp_en[$];
    reg_addr_t exp_addr[$];
    word_t     exp_data[$];

    int        edge_cnt   = 0;
    int        n_expected = 0;
    int        n_checked  = 0;

    mips_core_top i_mips_core_top (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_wb_en(input logic exp);
        if (wb_en_o !== exp)
            stop_run($sformatf("[FAIL] t=%0d ns: wb_en_o is %b, expected %b",
                               $time, wb_en_o, exp));
    endtask

    task automatic check_wb_addr(input reg_addr_t exp);
        if (wb_addr_o !== exp)
            stop_run($sformatf("[FAIL] t=%0d ns: wb_addr_o is r%0d, expected r%0d",
                               $time, wb_addr_o, exp));
    endtask

    task automatic check_wb_data(input word_t exp);
        if (wb_data_o !== exp)
            stop_run($sformatf("[FAIL] t=%0d ns: wb_data_o is %h, expected %h",
                               $time, wb_data_o, exp));
    endtask

    task automatic read_stim();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_valid;
        logic [31:0] f_inst;
        logic [31:0] f_en;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        fd = $fopen("mips_core_stim.txt", "r");
        if (fd == 0)
            stop_run("could not open the stimulus file mips_core_stim.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            cnt = $sscanf(line, "%h %h %h %h %h", f_valid, f_inst, f_en, f_addr, f_data);
            if (cnt == 5)  // comment and blank lines match nothing
            begin
                stim_valid.push_back(f_valid[0]);
                stim_inst.push_back(f_inst);
                stim_en.push_back(f_en[0]);
                stim_addr.push_back(f_addr[`MIPS_REG_ADDR_W-1:0]);
                stim_data.push_back(f_data);
            end
        end
        $fclose(fd);
        if (stim_valid.size() == 0)
            stop_run("the stimulus file holds no data lines");
    endtask

    // called on the falling edge
    task automatic drive_line(input int idx);
        inst_valid_i = stim_valid[idx];
        inst_i       = stim_inst[idx];
        if (stim_valid[idx])
        begin
            exp_due.push_back(edge_cnt + 1 + LATENCY);
            exp_en.push_back(stim_en[idx]);
            exp_addr.push_back(stim_addr[idx]);
            exp_data.push_back(stim_data[idx]);
            n_expected++;
        end
    endtask

    task automatic check_cycle();
        logic      e_en;
        reg_addr_t e_addr;
        word_t     e_data;
        if (exp_due.size() != 0 && exp_due[0] == edge_cnt)
        begin
            void'(exp_due.pop_front());
            e_en   = exp_en.pop_front();
            e_addr = exp_addr.pop_front();
            e_data = exp_data.pop_front();
            check_wb_en(e_en);
            if (e_en)
            begin
                check_wb_addr(e_addr);
                check_wb_data(e_data);
            end
            n_checked++;
        end
        else if (wb_en_o !== 1'b0)
        begin
            stop_run($sformatf("write-back to r%0d at %0d ns with no instruction due",
                               wb_addr_o, $time));
        end
    endtask

    // outputs settle well before the next falling edge
    task automatic next_cycle();
        @(posedge clk);
        edge_cnt++;
        #1;
        check_cycle();
        @(negedge clk);
    endtask

    initial
    begin
        inst_valid_i = 1'b0;
        inst_i       = '0;
        rst_n_i      = 1'b0;
        read_stim();
        n_lines     = stim_valid.size();
        stim_loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        for (int i = 0; i < n_lines; i++)
        begin
            drive_line(i);
            next_cycle();
        end
        inst_valid_i = 1'b0;
        inst_i       = '0;
        repeat (LATENCY + 1) next_cycle();  // drain plus one quiet cycle
        if (n_checked == n_expected && exp_due.size() == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("only %0d of %0d write-backs were checked", n_checked, n_expected);
            $display("TEST FAILED");
            $fatal(1, "write-backs missing at end of run");
        end
    end

    initial
    begin
        wait (stim_loaded === 1'b1);
        #((n_lines + WD_MARGIN) * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 n_lines + WD_MARGIN);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* vlog.f */
+incdir+.
mips_isa_pkg.sv
mips_pipe_pkg.sv
mips_regfile.sv
mips_id_stage.sv
mips_ex_stage.sv
mips_wb_stage.sv
mips_core_top.sv
tb_mips_core.sv
